// ==== source/bus_pkg.sv ====
package bus_pkg;

   // Bus and line geometry
   localparam int ADDR_W    = 16;
   localparam int LINE_W    = 128;
   localparam int BUS_W     = 32;
   localparam int BEATS     = LINE_W / BUS_W;
   localparam int N_MASTERS = 2;
   localparam int MEM_LINES = 4096;

   // Derived widths
   localparam int OFFSET_W = $clog2(LINE_W / 8);
   localparam int INDEX_W  = $clog2(MEM_LINES);
   localparam int BEAT_W   = $clog2(BEATS);
   localparam int MASTER_W = $clog2(N_MASTERS);

   typedef logic [ADDR_W-1:0] addr_t;
   typedef logic [LINE_W-1:0] line_t;
   typedef logic [BUS_W-1:0]  bus_word_t;

   // Master drive onto the shared bus
   typedef struct packed {
      logic      active;
      logic      header;
      logic      rw;
      addr_t     addr;
      bus_word_t data;
   } bus_drive_t;

   // Slave response back to the masters
   typedef struct packed {
      logic      rvalid;
      bus_word_t rdata;
      logic      ack;
   } bus_rsp_t;

endpackage

// ==== source/bus_arbiter.sv ====
`timescale 1ns/1ps

module bus_arbiter (
   input  logic                          bus_clk,
   input  logic                          reset,
   input  logic [bus_pkg::N_MASTERS-1:0] br,
   output logic [bus_pkg::N_MASTERS-1:0] bg,
   input  logic                          ack,
   input  bus_pkg::bus_drive_t           drive_in [bus_pkg::N_MASTERS],
   output bus_pkg::bus_drive_t           bus
);
   import bus_pkg::*;

   logic                busy;
   logic [MASTER_W-1:0] last_q;
   logic [MASTER_W-1:0] pick;
   logic                found;
   int unsigned         idx;

   // Bus is owned while any grant line is up
   assign busy = |bg;

   // Search starts just after the last winner
   always_comb begin
      pick  = last_q;
      found = 1'b0;
      idx   = 0;
      for (int k = 1; k <= N_MASTERS; k++) begin
         idx = (int'(last_q) + k) % N_MASTERS;
         if (!found && br[idx]) begin
            pick  = MASTER_W'(idx);
            found = 1'b1;
         end
      end
   end

   always_ff @(posedge bus_clk) begin
      if (reset) begin
         bg     <= '0;
         // Master 0 wins first after reset
         last_q <= MASTER_W'(N_MASTERS - 1);
      end else if (busy) begin
         // Grant held through the whole transfer
         if (ack)
            bg <= '0;
      end else if (found) begin
         bg       <= '0;
         bg[pick] <= 1'b1;
         last_q   <= pick;
      end
   end

   // Only the granted master reaches the slave
   always_comb begin
      bus = '0;
      for (int i = 0; i < N_MASTERS; i++) begin
         if (bg[i])
            bus = drive_in[i];
      end
   end

endmodule

// ==== source/cache_bus_controller.sv ====
`timescale 1ns/1ps

module cache_bus_controller (
   input  logic                bus_clk,
   input  logic                reset,
   output logic                br,
   input  logic                bg,
   output bus_pkg::bus_drive_t drive,
   input  bus_pkg::bus_rsp_t   rsp,
   input  logic                en,
   input  logic                wr,
   input  bus_pkg::addr_t      a,
   input  bus_pkg::line_t      write_data,
   output bus_pkg::line_t      read_data,
   output logic                r
);
   import bus_pkg::*;

   typedef enum logic [2:0] {
      S_IDLE,
      S_REQUEST,
      S_HEADER,
      S_BEATS,
      S_WAIT_ACK,
      S_DONE
   } state_t;

   state_t            state;
   logic [BEAT_W-1:0] beat_cnt;
   logic              armed;
   logic              accept;
   logic              listen;
   logic              wr_q;
   addr_t             a_q;
   line_t             wr_shift;
   line_t             rd_shift;

   // New request only once en has been seen low since the last one
   assign accept = (state == S_IDLE) && en && armed;

   // Response belongs to us only while granted and waiting
   assign listen = bg && (state == S_WAIT_ACK);

   always_ff @(posedge bus_clk) begin
      if (reset) begin
         state    <= S_IDLE;
         beat_cnt <= '0;
         armed    <= 1'b1;
      end else begin
         if (!en)
            armed <= 1'b1;
         case (state)
            S_IDLE: begin
               if (accept) begin
                  state <= S_REQUEST;
                  armed <= 1'b0;
               end
            end
            // br goes up here, grant earliest next cycle
            S_REQUEST: state <= S_HEADER;
            S_HEADER: begin
               if (bg) begin
                  beat_cnt <= '0;
                  state    <= wr_q ? S_BEATS : S_WAIT_ACK;
               end
            end
            S_BEATS: begin
               beat_cnt <= beat_cnt + 1'b1;
               if (beat_cnt == BEAT_W'(BEATS - 1))
                  state <= S_WAIT_ACK;
            end
            S_WAIT_ACK: begin
               if (listen && rsp.ack)
                  state <= S_DONE;
            end
            S_DONE: state <= S_IDLE;
            default: state <= S_IDLE;
         endcase
      end
   end

   // Request capture and beat shifting
   always_ff @(posedge bus_clk) begin
      if (accept) begin
         wr_q     <= wr;
         a_q      <= a;
         wr_shift <= write_data;
      end else if (state == S_BEATS) begin
         wr_shift <= wr_shift >> BUS_W;
      end
      // Beat 0 arrives first and ends up in the low word
      if (listen && rsp.rvalid)
         rd_shift <= {rsp.rdata, rd_shift[LINE_W-1:BUS_W]};
      // Last read beat comes with ack
      if (listen && rsp.ack && !wr_q)
         read_data <= {rsp.rdata, rd_shift[LINE_W-1:BUS_W]};
   end

   assign br = (state == S_REQUEST) || (state == S_HEADER) ||
               (state == S_BEATS) || (state == S_WAIT_ACK);

   // Header goes out in the first granted cycle
   assign drive.active = ((state == S_HEADER) && bg) || (state == S_BEATS);
   assign drive.header = (state == S_HEADER);
   assign drive.rw     = wr_q;
   assign drive.addr   = a_q;
   assign drive.data   = (state == S_BEATS) ? wr_shift[BUS_W-1:0] : '0;

   // One-cycle ready to the cache
   assign r = (state == S_DONE);

endmodule

// ==== source/mem_bus_controller.sv ====
`timescale 1ns/1ps

module mem_bus_controller (
   input  logic                bus_clk,
   input  logic                reset,
   input  bus_pkg::bus_drive_t bus,
   output bus_pkg::bus_rsp_t   rsp,
   output logic                mem_en,
   output logic                mem_wr,
   output bus_pkg::addr_t      mem_a,
   output bus_pkg::line_t      mem_write_data,
   input  bus_pkg::line_t      mem_read_data
);
   import bus_pkg::*;

   typedef enum logic [2:0] {
      M_IDLE,
      M_COLLECT,
      M_WRITE,
      M_READ,
      M_BEATS
   } state_t;

   state_t            state;
   logic [BEAT_W-1:0] beat_cnt;
   logic              last_beat;
   addr_t             addr_q;
   line_t             wline;

   assign last_beat = (beat_cnt == BEAT_W'(BEATS - 1));

   always_ff @(posedge bus_clk) begin
      if (reset) begin
         state    <= M_IDLE;
         beat_cnt <= '0;
      end else begin
         case (state)
            M_IDLE: begin
               // Header beat picks the direction
               if (bus.active && bus.header) begin
                  beat_cnt <= '0;
                  state    <= bus.rw ? M_COLLECT : M_READ;
               end
            end
            M_COLLECT: begin
               if (bus.active) begin
                  beat_cnt <= beat_cnt + 1'b1;
                  if (last_beat)
                     state <= M_WRITE;
               end
            end
            // Line write and ack in the same cycle
            M_WRITE: state <= M_IDLE;
            // Memory read issued, line back next cycle
            M_READ: begin
               beat_cnt <= '0;
               state    <= M_BEATS;
            end
            M_BEATS: begin
               beat_cnt <= beat_cnt + 1'b1;
               if (last_beat)
                  state <= M_IDLE;
            end
            default: state <= M_IDLE;
         endcase
      end
   end

   // Address latch and write line assembly
   always_ff @(posedge bus_clk) begin
      if ((state == M_IDLE) && bus.active && bus.header)
         addr_q <= bus.addr;
      if ((state == M_COLLECT) && bus.active)
         wline <= {bus.data, wline[LINE_W-1:BUS_W]};
   end

   assign mem_en         = (state == M_WRITE) || (state == M_READ);
   assign mem_wr         = (state == M_WRITE);
   assign mem_a          = addr_q;
   assign mem_write_data = wline;

   // Memory output holds while the bus is owned, so beats slice it directly
   assign rsp.rvalid = (state == M_BEATS);
   assign rsp.rdata  = mem_read_data[beat_cnt*BUS_W +: BUS_W];
   assign rsp.ack    = (state == M_WRITE) || ((state == M_BEATS) && last_beat);

endmodule

// ==== source/main_memory.sv ====
`timescale 1ns/1ps

module main_memory (
   input  logic           bus_clk,
   input  logic           mem_en,
   input  logic           mem_wr,
   input  bus_pkg::addr_t mem_a,
   input  bus_pkg::line_t mem_write_data,
   output bus_pkg::line_t mem_read_data
);
   import bus_pkg::*;

   line_t              mem [MEM_LINES];
   logic [INDEX_W-1:0] index;

   // Byte offset within the line is dropped
   assign index = mem_a[OFFSET_W +: INDEX_W];

   // Simulation starts from an all-zero memory
   initial begin
      for (int i = 0; i < MEM_LINES; i++)
         mem[i] = '0;
   end

   always_ff @(posedge bus_clk) begin
      if (mem_en) begin
         if (mem_wr)
            mem[index] <= mem_write_data;
         else
            // Read data lands one cycle after enable and holds
            mem_read_data <= mem[index];
      end
   end

endmodule

// ==== source/full_memory.sv ====
`timescale 1ns/1ps

module full_memory (
   input  logic           bus_clk,
   input  logic           reset,
   // Instruction cache side
   input  logic           ic_en,
   input  logic           ic_wr,
   input  bus_pkg::addr_t ic_a,
   input  bus_pkg::line_t ic_write_data,
   output bus_pkg::line_t ic_read_data,
   output logic           ic_r,
   // Data cache side
   input  logic           dc_en,
   input  logic           dc_wr,
   input  bus_pkg::addr_t dc_a,
   input  bus_pkg::line_t dc_write_data,
   output bus_pkg::line_t dc_read_data,
   output logic           dc_r
);
   import bus_pkg::*;

   // Arbitration lines
   logic [N_MASTERS-1:0] br;
   logic [N_MASTERS-1:0] bg;

   // Shared bus
   bus_drive_t drive [N_MASTERS];
   bus_drive_t bus;
   bus_rsp_t   rsp;

   // Memory port to main memory
   logic  mem_en;
   logic  mem_wr;
   addr_t mem_a;
   line_t mem_write_data;
   line_t mem_read_data;

   bus_arbiter bus_arbiter_inst (
      .bus_clk  (bus_clk),
      .reset    (reset),
      .br       (br),
      .bg       (bg),
      .ack      (rsp.ack),
      .drive_in (drive),
      .bus      (bus)
   );

   // Master 0
   cache_bus_controller icache_port (
      .bus_clk    (bus_clk),
      .reset      (reset),
      .br         (br[0]),
      .bg         (bg[0]),
      .drive      (drive[0]),
      .rsp        (rsp),
      .en         (ic_en),
      .wr         (ic_wr),
      .a          (ic_a),
      .write_data (ic_write_data),
      .read_data  (ic_read_data),
      .r          (ic_r)
   );

   // Master 1
   cache_bus_controller dcache_port (
      .bus_clk    (bus_clk),
      .reset      (reset),
      .br         (br[1]),
      .bg         (bg[1]),
      .drive      (drive[1]),
      .rsp        (rsp),
      .en         (dc_en),
      .wr         (dc_wr),
      .a          (dc_a),
      .write_data (dc_write_data),
      .read_data  (dc_read_data),
      .r          (dc_r)
   );

   mem_bus_controller mem_port (
      .bus_clk        (bus_clk),
      .reset          (reset),
      .bus            (bus),
      .rsp            (rsp),
      .mem_en         (mem_en),
      .mem_wr         (mem_wr),
      .mem_a          (mem_a),
      .mem_write_data (mem_write_data),
      .mem_read_data  (mem_read_data)
   );

   main_memory main_memory_inst (
      .bus_clk        (bus_clk),
      .mem_en         (mem_en),
      .mem_wr         (mem_wr),
      .mem_a          (mem_a),
      .mem_write_data (mem_write_data),
      .mem_read_data  (mem_read_data)
   );

endmodule

// ==== dv/full_memory_properties.sv ====
`timescale 1ns/1ps

module full_memory_properties #(
   parameter int N = bus_pkg::N_MASTERS
) (
   input logic         bus_clk,
   input logic         reset,
   input logic [N-1:0] br,
   input logic [N-1:0] bg,
   input logic         ack,
   input logic         ready
);

   // Count of failed checks in this instance
   int failures = 0;

   // At most one master owns the bus
   grant_onehot: assert property (@(posedge bus_clk) disable iff (reset)
      $onehot0(bg))
      else begin
         $error("bus grant is neither zero nor one-hot: %b", bg);
         failures++;
      end

   // Grant may only change after the transfer is acknowledged
   grant_held: assert property (@(posedge bus_clk) disable iff (reset)
      (|bg && !ack) |=> $stable(bg))
      else begin
         $error("bus grant changed before ack");
         failures++;
      end

   // Ready to the cache lasts a single cycle
   ready_pulse: assert property (@(posedge bus_clk) disable iff (reset)
      ready |=> !ready)
      else begin
         $error("ready pulse wider than one cycle");
         failures++;
      end

   // Quiet through reset and the cycle after it
   reset_quiet: assert property (@(posedge bus_clk)
      reset |=> (br == '0 && bg == '0 && !ready))
      else begin
         $error("request, grant or ready high around reset");
         failures++;
      end

endmodule

// Arbiter sees both request and grant vectors, no ready of its own
bind bus_arbiter full_memory_properties #(.N(bus_pkg::N_MASTERS)) arbiter_props (
   .bus_clk (bus_clk),
   .reset   (reset),
   .br      (br),
   .bg      (bg),
   .ack     (ack),
   .ready   (1'b0)
);

// Each cache port checks its own grant and ready
bind cache_bus_controller full_memory_properties #(.N(1)) port_props (
   .bus_clk (bus_clk),
   .reset   (reset),
   .br      (br),
   .bg      (bg),
   .ack     (rsp.ack),
   .ready   (r)
);

// ==== dv/full_memory_tb.sv ====
`timescale 1ns/1ps

module full_memory_tb;
   import bus_pkg::*;

   // Transfers per test, sizes the run limit
   localparam int T1_XFERS       = 2;
   localparam int T2_XFERS       = 2;
   localparam int T3_XFERS       = 4;
   localparam int T4_XFERS       = 5;
   localparam int T5_XFERS       = 200;
   localparam int TIMEOUT_CYCLES =
      (T1_XFERS + T2_XFERS + T3_XFERS + T4_XFERS + T5_XFERS) * 16 + 200;
   // en to r on an idle bus
   localparam int IDLE_LATENCY = 8;
   // Random traffic stays in a small line window to force sharing
   localparam int POOL_BASE  = 'h100;
   localparam int POOL_LINES = 32;

   logic  bus_clk;
   logic  reset;
   logic  ic_en;
   logic  ic_wr;
   addr_t ic_a;
   line_t ic_write_data;
   line_t ic_read_data;
   logic  ic_r;
   logic  dc_en;
   logic  dc_wr;
   addr_t dc_a;
   line_t dc_write_data;
   line_t dc_read_data;
   logic  dc_r;

   // Reference contents of main memory, one entry per line
   line_t model [MEM_LINES];

   int cycle;
   int checks;
   int errors;
   int tests_run;
   int ic_done_cycle;
   int dc_done_cycle;

   full_memory full_memory_inst (
      .bus_clk       (bus_clk),
      .reset         (reset),
      .ic_en         (ic_en),
      .ic_wr         (ic_wr),
      .ic_a          (ic_a),
      .ic_write_data (ic_write_data),
      .ic_read_data  (ic_read_data),
      .ic_r          (ic_r),
      .dc_en         (dc_en),
      .dc_wr         (dc_wr),
      .dc_a          (dc_a),
      .dc_write_data (dc_write_data),
      .dc_read_data  (dc_read_data),
      .dc_r          (dc_r)
   );

   initial begin
      bus_clk = 1'b0;
      forever #2 bus_clk = ~bus_clk;
   end

   always @(posedge bus_clk)
      cycle <= cycle + 1;

   // Run limit
   initial begin
      wait (cycle >= TIMEOUT_CYCLES);
      $display("timeout: run did not end within %0d cycles", TIMEOUT_CYCLES);
      $display("SIMULATION FAILED");
      $finish;
   end

   task automatic apply_reset();
      @(negedge bus_clk);
      reset = 1'b1;
      repeat (3) @(posedge bus_clk);
      @(negedge bus_clk);
      reset = 1'b0;
   endtask

   // One cache request held until r, then checked against the model
   task automatic transfer(input int port, input logic is_wr, input addr_t addr,
                           input line_t wdata, output int latency);
      line_t got;
      line_t exp;
      string name;
      logic  ready;
      @(negedge bus_clk);
      if (port == 0) begin
         ic_en         = 1'b1;
         ic_wr         = is_wr;
         ic_a          = addr;
         ic_write_data = wdata;
      end else begin
         dc_en         = 1'b1;
         dc_wr         = is_wr;
         dc_a          = addr;
         dc_write_data = wdata;
      end
      latency = 0;
      do begin
         @(negedge bus_clk);
         latency++;
         ready = (port == 0) ? ic_r : dc_r;
      end while (!ready);
      // Drop en in the r cycle so the next request is a new one
      if (port == 0) begin
         ic_en         = 1'b0;
         ic_done_cycle = cycle;
      end else begin
         dc_en         = 1'b0;
         dc_done_cycle = cycle;
      end
      // Line index is address bits 15 to 4
      if (is_wr) begin
         model[addr[15:4]] = wdata;
      end else begin
         got  = (port == 0) ? ic_read_data : dc_read_data;
         name = (port == 0) ? "ic_read_data" : "dc_read_data";
         exp  = model[addr[15:4]];
         checks++;
         assert (got === exp) else begin
            $display("mismatch %s at addr %h: got %h exp %h", name, addr, got, exp);
            errors++;
         end
      end
   endtask

   task automatic check_latency(input int got);
      checks++;
      assert (got == IDLE_LATENCY) else begin
         $display("mismatch r latency: got %h exp %h", got, IDLE_LATENCY);
         errors++;
      end
   endtask

   // Master 0 wins a tie when master 1 was granted last
   task automatic check_ic_first();
      checks++;
      assert (ic_done_cycle < dc_done_cycle) else begin
         $display("icache port did not finish before dcache port on a tie");
         errors++;
      end
   endtask

   task automatic random_traffic(input int port, input int count);
      int    gap;
      int    lat;
      int    line_idx;
      logic  is_wr;
      addr_t addr;
      line_t wdata;
      for (int i = 0; i < count; i++) begin
         gap      = $urandom_range(3, 0);
         is_wr    = 1'($urandom_range(1, 0));
         line_idx = POOL_BASE + $urandom_range(POOL_LINES - 1, 0);
         // Random byte offset inside the line
         addr     = addr_t'((line_idx << 4) | ($urandom & 'hF));
         wdata    = {$urandom(), $urandom(), $urandom(), $urandom()};
         repeat (gap) @(negedge bus_clk);
         transfer(port, is_wr, addr, wdata, lat);
      end
   endtask

   task automatic report_test(input int num, input string what, input int err_before);
      tests_run++;
      if (errors == err_before)
         $display("test %0d %s: pass", num, what);
      else
         $display("test %0d %s: %0d errors", num, what, errors - err_before);
   endtask

   initial begin
      int    lat_a;
      int    lat_b;
      int    err0;
      line_t line_a;
      line_t line_b;
      line_t line_c;
      void'($urandom(89970));
      reset         = 1'b1;
      ic_en         = 1'b0;
      ic_wr         = 1'b0;
      ic_a          = '0;
      ic_write_data = '0;
      dc_en         = 1'b0;
      dc_wr         = 1'b0;
      dc_a          = '0;
      dc_write_data = '0;
      cycle         = 0;
      checks        = 0;
      errors        = 0;
      tests_run     = 0;
      for (int i = 0; i < MEM_LINES; i++)
         model[i] = '0;
      apply_reset();

      // dcache write then read back, idle bus latency on both
      err0   = errors;
      line_a = {$urandom(), $urandom(), $urandom(), $urandom()};
      transfer(1, 1'b1, 16'h1230, line_a, lat_a);
      check_latency(lat_a);
      transfer(1, 1'b0, 16'h1230, '0, lat_b);
      check_latency(lat_b);
      report_test(1, "dcache write and read", err0);

      // Written by dcache, read by icache
      err0   = errors;
      line_b = {$urandom(), $urandom(), $urandom(), $urandom()};
      transfer(1, 1'b1, 16'h0450, line_b, lat_a);
      transfer(0, 1'b0, 16'h0450, '0, lat_b);
      report_test(2, "shared memory across ports", err0);

      // Ties right after reset, icache first each time
      apply_reset();
      err0   = errors;
      line_c = {$urandom(), $urandom(), $urandom(), $urandom()};
      line_a = {$urandom(), $urandom(), $urandom(), $urandom()};
      fork
         transfer(0, 1'b1, 16'h0a00, line_c, lat_a);
         transfer(1, 1'b1, 16'h0b00, line_a, lat_b);
      join
      check_ic_first();
      fork
         transfer(0, 1'b0, 16'h0b00, '0, lat_a);
         transfer(1, 1'b0, 16'h0a00, '0, lat_b);
      join
      check_ic_first();
      report_test(3, "simultaneous requests", err0);

      // Offset bits alias one line, untouched lines read as zero
      err0   = errors;
      line_b = {$urandom(), $urandom(), $urandom(), $urandom()};
      transfer(1, 1'b1, 16'h2340, line_b, lat_a);
      transfer(0, 1'b0, 16'h234f, '0, lat_a);
      transfer(1, 1'b0, 16'h2348, '0, lat_a);
      transfer(0, 1'b0, 16'h3ff0, '0, lat_a);
      transfer(1, 1'b0, 16'hfff7, '0, lat_a);
      report_test(4, "aliasing and unwritten lines", err0);

      // Mixed traffic from both ports at once
      err0 = errors;
      fork
         random_traffic(0, T5_XFERS / 2);
         random_traffic(1, T5_XFERS / 2);
      join
      report_test(5, "random mixed traffic", err0);

      // Bound grant and ready checks over the whole run
      err0   = errors;
      errors += full_memory_inst.bus_arbiter_inst.arbiter_props.failures +
                full_memory_inst.icache_port.port_props.failures +
                full_memory_inst.dcache_port.port_props.failures;
      report_test(6, "bus protocol properties", err0);

      $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
      if (errors == 0)
         $display("SIMULATION PASSED");
      else
         $display("SIMULATION FAILED");
      $finish;
   end

endmodule

// ==== vlog.f ====
source/bus_pkg.sv
source/bus_arbiter.sv
source/cache_bus_controller.sv
source/mem_bus_controller.sv
source/main_memory.sv
source/full_memory.sv
dv/full_memory_properties.sv
dv/full_memory_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= full_memory_tb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
FAIL_MSG  ?= SIMULATION FAILED

EXE := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build: $(EXE)

$(EXE): $(shell cat $(FILELIST))
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -o V$(TOP)

sim: $(EXE)
	$(EXE) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi; \
	if [ $$status -ne 0 ]; then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
